//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_tenyr_soc
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_tenyr_soc.sv
`default_nettype none

module tb_tenyr_soc;
    timeunit 1ns;
    timeprecision 100ps;
    import tenyr_bus_pkg::*;
    import tenyr_dev_pkg::*;

    localparam int MAX_CYCLES = 4000;         // About 20 times the transaction count.
    localparam int SCAN_LIMIT = 4 * SCAN_DIV; // Longest gap for any anode.
    localparam int RAM_TESTS  = 32;

    // Active low, gfedcba.
    localparam logic [6:0] SEG_TABLE [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12,
        7'h02, 7'h78, 7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};
    localparam logic [ADDR_W-1:0] UNMAPPED [6] = '{32'h0000_0000, 32'h0000_0102,
        32'h0000_0204, 32'h0000_0fff, 32'h0000_1400, 32'hffff_ffff};

    logic                   clk = 1'b0;
    logic                   rst_i, cyc_i, stb_i, we_i, ack_o;
    logic [ADDR_W-1:0]      adr_i;
    logic [DATA_W-1:0]      dat_i, dat_o;
    logic [SEL_W-1:0]       sel_i;
    logic [7:0]             seg_o;
    logic [SEG7_DIGITS-1:0] an_o;
    logic [GPIO_COUNT-1:0]  gpio_i, gpio_o, gpio_oe_o;

    integer                seed = 32'h6b5;
    int                    errors;
    int                    cycles;
    int                    last_seen [SEG7_DIGITS];
    bit                    started;
    bit                    scan_hold; // Model and display registers may differ.
    bit                    prev_ack;
    logic [DATA_W-1:0]     ram_model [2**RAM_ABITS];
    logic [ADDR_W-1:0]     ram_adr [RAM_TESTS];
    logic [15:0]           value_m;
    logic [3:0]            dp_m;
    logic [GPIO_COUNT-1:0] out_m, dir_m, in_m;

    tenyr_soc dut_i (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("[ERROR] %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic check_true(input string what, input bit cond);
        assert (cond) else begin
            errors++;
            $display("Check failed at cycle %0d: %s", cycles, what);
        end
    endtask

    function automatic target_e target_of(input logic [ADDR_W-1:0] a);
        if ((a >> RAM_ABITS) == (RAM_BASE >> RAM_ABITS)) return TGT_RAM;
        if ((a >> 1) == (SEG7_BASE >> 1)) return TGT_SEG7;
        if ((a >> 2) == (GPIO_BASE >> 2)) return TGT_GPIO;
        return TGT_NONE;
    endfunction

    function automatic logic [DATA_W-1:0] expected_read(input logic [ADDR_W-1:0] a);
        case (target_of(a))
            TGT_RAM:  return ram_model[a[RAM_ABITS-1:0]];
            TGT_SEG7: return a[0] ? {28'h0, dp_m} : {16'h0, value_m};
            TGT_GPIO: begin
                case (a[1:0])
                    2'd0:    return 32'(out_m);
                    2'd1:    return 32'(dir_m);
                    2'd2:    return 32'(in_m);
                    default: return '0;
                endcase
            end
            default:  return {DATA_W{1'b1}};
        endcase
    endfunction

    // One master cycle, held until ack_o.
    task automatic bus_access(input bit we, input logic [ADDR_W-1:0] adr,
                              input logic [DATA_W-1:0] dat, input logic [SEL_W-1:0] sel,
                              output logic [DATA_W-1:0] rdat);
        started = 1'b1;
        @(posedge clk);
        cyc_i <= 1'b1;
        stb_i <= 1'b1;
        we_i  <= we;
        adr_i <= adr;
        dat_i <= dat;
        sel_i <= sel;
        do @(negedge clk); while (ack_o !== 1'b1);
        rdat = dat_o;
        @(posedge clk);
        cyc_i <= 1'b0; // Dropped in the cycle after ack_o.
        stb_i <= 1'b0;
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat,
                             input logic [SEL_W-1:0] sel);
        logic [DATA_W-1:0] rdat;
        scan_hold = 1'b1;
        bus_access(1'b1, adr, dat, sel, rdat);
        case (target_of(adr))
            TGT_RAM: begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (sel[b]) ram_model[adr[RAM_ABITS-1:0]][8*b +: 8] = dat[8*b +: 8];
                end
            end
            TGT_SEG7: begin
                if (adr[0]) dp_m = dat[3:0];
                else value_m = dat[15:0];
            end
            TGT_GPIO: begin
                if (adr[1:0] == 2'd0) out_m = dat[GPIO_COUNT-1:0];
                else if (adr[1:0] == 2'd1) dir_m = dat[GPIO_COUNT-1:0];
            end
            default: ; // Unmapped writes are dropped.
        endcase
        scan_hold = 1'b0;
    endtask

    task automatic bus_read(input string name, input logic [ADDR_W-1:0] adr);
        logic [DATA_W-1:0] rdat;
        bus_access(1'b0, adr, '0, '1, rdat);
        check_equal(name, expected_read(adr), rdat);
    endtask

    // Handshake and display scan, sampled mid-cycle.
    always @(negedge clk) begin
        if (!rst_i) begin
            if (!started) begin
                check_true("ack_o or gpio_oe_o set before the first transaction",
                           ack_o === 1'b0 && gpio_oe_o === '0);
            end
            if (ack_o === 1'b1) begin
                check_true("ack_o rose without a held request", cyc_i && stb_i);
                check_true("ack_o stayed high for more than one cycle", !prev_ack);
            end
            prev_ack = (ack_o === 1'b1);
            check_true("an_o is not active-low one-hot", $onehot(~an_o));
            for (int d = 0; d < SEG7_DIGITS; d++) begin
                if (an_o[d] === 1'b0) begin
                    last_seen[d] = cycles;
                    if (!scan_hold) begin
                        check_equal("display scan", {24'h0, ~dp_m[d], SEG_TABLE[value_m[4*d +: 4]]},
                                    {24'h0, seg_o});
                    end
                end
                check_true("an anode was not scanned in time", cycles - last_seen[d] <= SCAN_LIMIT);
            end
        end
    end

    initial begin
        logic [ADDR_W-1:0] adr;
        rst_i   = 1'b1;
        cyc_i   = 1'b0;
        stb_i   = 1'b0;
        we_i    = 1'b0;
        adr_i   = '0;
        dat_i   = '0;
        sel_i   = '0;
        gpio_i  = '0;
        value_m = '0;
        dp_m    = '0;
        out_m   = '0;
        dir_m   = '0;
        in_m    = '0;
        repeat (2) @(posedge clk);
        rst_i <= 1'b0;
        foreach (last_seen[d]) last_seen[d] = cycles;
        repeat (4) @(posedge clk); // Idle after reset.

        for (int i = 0; i < RAM_TESTS; i++) begin
            ram_adr[i] = RAM_BASE | ($random(seed) & ((1 << RAM_ABITS) - 1));
            bus_write(ram_adr[i], $random(seed), '1);
        end
        foreach (ram_adr[i]) bus_read("ram full word", ram_adr[i]);
        foreach (ram_adr[i]) bus_write(ram_adr[i], $random(seed), SEL_W'($random(seed)));
        foreach (ram_adr[i]) bus_read("ram byte enables", ram_adr[i]);

        repeat (4) begin
            bus_write(GPIO_BASE + GPIO_REG_OUT, $random(seed), '1);
            bus_write(GPIO_BASE + GPIO_REG_DIR, $random(seed), '1);
            @(negedge clk);
            check_equal("gpio_o pins", 32'(out_m), 32'(gpio_o));
            check_equal("gpio_oe_o pins", 32'(dir_m), 32'(gpio_oe_o));
            bus_read("gpio out register", GPIO_BASE + GPIO_REG_OUT);
            bus_read("gpio dir register", GPIO_BASE + GPIO_REG_DIR);
        end
        repeat (4) begin
            @(posedge clk);
            in_m = GPIO_COUNT'($random(seed));
            gpio_i <= in_m;
            repeat (4) @(posedge clk); // Through the synchronizer.
            bus_read("gpio input register", GPIO_BASE + GPIO_REG_IN);
        end
        bus_read("gpio unused register", GPIO_BASE + 32'd3);

        repeat (4) begin
            bus_write(SEG7_BASE + SEG7_REG_VALUE, $random(seed), '1);
            bus_write(SEG7_BASE + SEG7_REG_DP, $random(seed), '1);
            bus_read("seg7 value register", SEG7_BASE + SEG7_REG_VALUE);
            bus_read("seg7 dp register", SEG7_BASE + SEG7_REG_DP);
            repeat (SCAN_LIMIT + 4) @(posedge clk); // Full pass over all digits.
        end

        // Later entries share a word index with a tested RAM word.
        for (int i = 0; i < 16; i++) begin
            adr = (i < 6) ? UNMAPPED[i] : (ram_adr[i] | 32'h8000_0000);
            bus_read("unmapped read", adr);
            bus_write(adr, $random(seed), '1);
        end
        foreach (ram_adr[i]) bus_read("ram after unmapped writes", ram_adr[i]);
        bus_read("seg7 value after unmapped writes", SEG7_BASE + SEG7_REG_VALUE);
        bus_read("seg7 dp after unmapped writes", SEG7_BASE + SEG7_REG_DP);
        bus_read("gpio out after unmapped writes", GPIO_BASE + GPIO_REG_OUT);
        bus_read("gpio dir after unmapped writes", GPIO_BASE + GPIO_REG_DIR);

        repeat (SCAN_LIMIT) @(posedge clk);
        $display("Checks finished with %0d errors in %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
src/tenyr_dev_pkg.sv
src/tenyr_bus_pkg.sv
src/wb_if.sv
src/bus_sequencer.sv
src/wb_mux.sv
src/ram.sv
src/scan_timer.sv
src/seg7.sv
src/gpio.sv
src/tenyr_soc.sv
bench/tb_tenyr_soc.sv

//--- src/bus_sequencer.sv
`default_nettype none

module bus_sequencer (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              cyc_i,
    input  logic                              stb_i,
    input  logic                              we_i,
    input  logic [tenyr_bus_pkg::ADDR_W-1:0]  adr_i,
    input  logic [tenyr_bus_pkg::DATA_W-1:0]  dat_i,
    input  logic [tenyr_bus_pkg::SEL_W-1:0]   sel_i,
    output logic [tenyr_bus_pkg::DATA_W-1:0]  dat_o,
    output logic                              ack_o,
    wb_if.master                              bus
);
    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESPOND
    } state_e;

    state_e state;
    logic   accept;

    assign accept = (state == IDLE) && cyc_i && stb_i; // New request seen.

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state   <= IDLE;
            bus.stb <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state   <= ACCESS;
                        bus.stb <= 1'b1;
                    end
                end
                ACCESS: begin
                    if (bus.ack) begin
                        state   <= RESPOND;
                        bus.stb <= 1'b0; // One access per request.
                    end
                end
                default: state <= IDLE; // RESPOND lasts one cycle.
            endcase
        end
    end

    // Request and response payload.
    always_ff @(posedge clk) begin
        if (accept) begin
            bus.adr   <= adr_i;
            bus.dat_w <= dat_i;
            bus.we    <= we_i;
            bus.sel   <= sel_i;
        end
        if (state == ACCESS && bus.ack) begin
            dat_o <= bus.dat_r;
        end
    end

    assign ack_o = (state == RESPOND);

endmodule

`default_nettype wire

//--- src/gpio.sv
`default_nettype none

module gpio (
    input  logic                                 clk,
    input  logic                                 rst_i,
    wb_if.slave                                  bus,
    input  logic [tenyr_dev_pkg::GPIO_COUNT-1:0] gpio_i,
    output logic [tenyr_dev_pkg::GPIO_COUNT-1:0] gpio_o,
    output logic [tenyr_dev_pkg::GPIO_COUNT-1:0] gpio_oe_o
);
    import tenyr_dev_pkg::*;

    logic [GPIO_COUNT-1:0] out_q;
    logic [GPIO_COUNT-1:0] dir_q;
    logic [GPIO_COUNT-1:0] sync0_q;
    logic [GPIO_COUNT-1:0] sync1_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_q <= '0;
            dir_q <= '0; // Pins start as inputs.
        end else if (bus.stb && bus.we) begin
            case (bus.adr.dev.regno)
                GPIO_REG_OUT: out_q <= bus.dat_w[GPIO_COUNT-1:0];
                GPIO_REG_DIR: dir_q <= bus.dat_w[GPIO_COUNT-1:0];
                default: ;
            endcase
        end
    end

    // Two-stage input synchronizer.
    always_ff @(posedge clk) begin
        sync0_q <= gpio_i;
        sync1_q <= sync0_q;
    end

    always_comb begin
        bus.dat_r = '0;
        case (bus.adr.dev.regno)
            GPIO_REG_OUT: bus.dat_r[GPIO_COUNT-1:0] = out_q;
            GPIO_REG_DIR: bus.dat_r[GPIO_COUNT-1:0] = dir_q;
            GPIO_REG_IN:  bus.dat_r[GPIO_COUNT-1:0] = sync1_q;
            default: ;
        endcase
    end

    assign bus.ack   = bus.stb;
    assign gpio_o    = out_q;
    assign gpio_oe_o = dir_q;

endmodule

`default_nettype wire

//--- src/ram.sv
`default_nettype none

module ram (
    input  logic clk,
    input  logic rst_i,
    wb_if.slave  bus
);
    import tenyr_bus_pkg::*;
    import tenyr_dev_pkg::*;

    logic [DATA_W-1:0]    mem [2**RAM_ABITS];
    logic [RAM_ABITS-1:0] idx;
    logic                 start;

    assign idx   = bus.adr.ram.index;
    assign start = bus.stb && !bus.ack; // First cycle of the strobe.

    always_ff @(posedge clk) begin
        if (rst_i) begin
            bus.ack <= 1'b0;
        end else begin
            bus.ack <= start; // High for one cycle only.
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            if (bus.we) begin
                for (int b = 0; b < SEL_W; b++) begin
                    if (bus.sel[b]) begin
                        mem[idx][8*b +: 8] <= bus.dat_w[8*b +: 8];
                    end
                end
            end
            bus.dat_r <= mem[idx]; // Valid with the acknowledge.
        end
    end

endmodule

`default_nettype wire

//--- src/scan_timer.sv
`default_nettype none

module scan_timer (
    input  logic                              clk,
    input  logic                              rst_i,
    output logic [tenyr_dev_pkg::DIGIT_W-1:0] digit_o
);
    import tenyr_dev_pkg::*;

    logic [SCAN_W-1:0] div_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            div_q   <= '0;
            digit_o <= '0;
        end else if (div_q == SCAN_W'(SCAN_DIV - 1)) begin
            div_q   <= '0;
            digit_o <= digit_o + 1'b1; // Wraps past the last digit.
        end else begin
            div_q <= div_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/seg7.sv
`default_nettype none

module seg7 (
    input  logic                                  clk,
    input  logic                                  rst_i,
    wb_if.slave                                   bus,
    output logic [7:0]                            seg_o,
    output logic [tenyr_dev_pkg::SEG7_DIGITS-1:0] an_o
);
    import tenyr_dev_pkg::*;

    logic [4*SEG7_DIGITS-1:0] value_q;
    logic [SEG7_DIGITS-1:0]   dp_q;
    logic [DIGIT_W-1:0]       digit;

    // Active low, bit order gfedcba.
    function automatic logic [6:0] hex_to_seg(input logic [3:0] nib);
        case (nib)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'ha: return 7'b0001000;
            4'hb: return 7'b0000011;
            4'hc: return 7'b1000110;
            4'hd: return 7'b0100001;
            4'he: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    scan_timer scan_i (
        .clk     ( clk   ),
        .rst_i   ( rst_i ),
        .digit_o ( digit )
    );

    always_ff @(posedge clk) begin
        if (rst_i) begin
            value_q <= '0;
            dp_q    <= '0; // All points off.
        end else if (bus.stb && bus.we) begin
            case (bus.adr.dev.regno)
                SEG7_REG_VALUE: value_q <= bus.dat_w[4*SEG7_DIGITS-1:0];
                SEG7_REG_DP:    dp_q    <= bus.dat_w[SEG7_DIGITS-1:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        bus.dat_r = '0; // Unused bits read as zero.
        case (bus.adr.dev.regno)
            SEG7_REG_VALUE: bus.dat_r[4*SEG7_DIGITS-1:0] = value_q;
            SEG7_REG_DP:    bus.dat_r[SEG7_DIGITS-1:0]   = dp_q;
            default: ;
        endcase
    end

    assign bus.ack = bus.stb;

    always_comb begin
        an_o        = '1;
        an_o[digit] = 1'b0; // One anode at a time.
    end

    assign seg_o[6:0] = hex_to_seg(value_q[4*digit +: 4]);
    assign seg_o[7]   = ~dp_q[digit];

endmodule

`default_nettype wire

//--- src/tenyr_bus_pkg.sv
`default_nettype none

package tenyr_bus_pkg;

    localparam int DATA_W = 32;         // Bus data width.
    localparam int ADDR_W = 32;         // Word address width.
    localparam int SEL_W  = DATA_W / 8; // One enable per byte.

    localparam logic [ADDR_W-1:0] RAM_BASE  = 32'h0000_1000;
    localparam logic [ADDR_W-1:0] RAM_MASK  = {ADDR_W{1'b1}} << tenyr_dev_pkg::RAM_ABITS;
    localparam logic [ADDR_W-1:0] SEG7_BASE = 32'h0000_0100;
    localparam logic [ADDR_W-1:0] SEG7_MASK = {ADDR_W{1'b1}} << 1; // Two words.
    localparam logic [ADDR_W-1:0] GPIO_BASE = 32'h0000_0200;
    localparam logic [ADDR_W-1:0] GPIO_MASK = {ADDR_W{1'b1}} << 2; // Four words.

    localparam logic [DATA_W-1:0] DEFAULT_DATA = {DATA_W{1'b1}}; // Unmapped read value.

    typedef enum logic [1:0] {
        TGT_RAM,
        TGT_SEG7,
        TGT_GPIO,
        TGT_NONE
    } target_e;

    typedef struct packed {
        logic [ADDR_W-tenyr_dev_pkg::RAM_ABITS-1:0] tag;   // Window bits.
        logic [tenyr_dev_pkg::RAM_ABITS-1:0]        index; // Word inside the RAM.
    } ram_addr_t;

    typedef struct packed {
        logic [ADDR_W-9:0] page;  // Device page.
        logic [7:0]        regno; // Register number.
    } dev_addr_t;

    // Same address word, seen by the decoder, the RAM and the devices.
    typedef union packed {
        logic [ADDR_W-1:0] word;
        ram_addr_t         ram;
        dev_addr_t         dev;
    } bus_addr_u;

endpackage

`default_nettype wire

//--- src/tenyr_dev_pkg.sv
`default_nettype none

package tenyr_dev_pkg;

    localparam int RAM_ABITS = 10; // 1024 words.

    localparam int GPIO_COUNT = 24;

    localparam int SEG7_DIGITS = 4;
    localparam int DIGIT_W     = $clog2(SEG7_DIGITS);
    localparam int SCAN_DIV    = 8; // Short scan for simulation.
    localparam int SCAN_W      = $clog2(SCAN_DIV);

    localparam logic [7:0] SEG7_REG_VALUE = 8'd0; // Four hex nibbles.
    localparam logic [7:0] SEG7_REG_DP    = 8'd1; // Decimal points.

    localparam logic [7:0] GPIO_REG_OUT = 8'd0;
    localparam logic [7:0] GPIO_REG_DIR = 8'd1; // Ones enable the driver.
    localparam logic [7:0] GPIO_REG_IN  = 8'd2; // Read only.

endpackage

`default_nettype wire

//--- src/tenyr_soc.sv
`default_nettype none

module tenyr_soc (
    input  logic                                  clk,
    input  logic                                  rst_i,
    input  logic                                  cyc_i,
    input  logic                                  stb_i,
    input  logic                                  we_i,
    input  logic [tenyr_bus_pkg::ADDR_W-1:0]      adr_i,
    input  logic [tenyr_bus_pkg::DATA_W-1:0]      dat_i,
    input  logic [tenyr_bus_pkg::SEL_W-1:0]       sel_i,
    output logic [tenyr_bus_pkg::DATA_W-1:0]      dat_o,
    output logic                                  ack_o,
    output logic [7:0]                            seg_o,
    output logic [tenyr_dev_pkg::SEG7_DIGITS-1:0] an_o,
    input  logic [tenyr_dev_pkg::GPIO_COUNT-1:0]  gpio_i,
    output logic [tenyr_dev_pkg::GPIO_COUNT-1:0]  gpio_o,
    output logic [tenyr_dev_pkg::GPIO_COUNT-1:0]  gpio_oe_o
);
    wb_if up_bus ();
    wb_if ram_bus ();
    wb_if seg_bus ();
    wb_if gpio_bus ();

    bus_sequencer seq_i (
        .clk   ( clk    ),
        .rst_i ( rst_i  ),
        .cyc_i ( cyc_i  ),
        .stb_i ( stb_i  ),
        .we_i  ( we_i   ),
        .adr_i ( adr_i  ),
        .dat_i ( dat_i  ),
        .sel_i ( sel_i  ),
        .dat_o ( dat_o  ),
        .ack_o ( ack_o  ),
        .bus   ( up_bus )
    );

    wb_mux mux_i (
        .up       ( up_bus   ),
        .ram_bus  ( ram_bus  ),
        .seg_bus  ( seg_bus  ),
        .gpio_bus ( gpio_bus )
    );

    ram ram_i (
        .clk   ( clk     ),
        .rst_i ( rst_i   ),
        .bus   ( ram_bus )
    );

    seg7 seg7_i (
        .clk   ( clk     ),
        .rst_i ( rst_i   ),
        .bus   ( seg_bus ),
        .seg_o ( seg_o   ),
        .an_o  ( an_o    )
    );

    gpio gpio_i0 (
        .clk       ( clk       ),
        .rst_i     ( rst_i     ),
        .bus       ( gpio_bus  ),
        .gpio_i    ( gpio_i    ),
        .gpio_o    ( gpio_o    ),
        .gpio_oe_o ( gpio_oe_o )
    );

endmodule

`default_nettype wire

//--- src/wb_if.sv
`default_nettype none

interface wb_if;
    import tenyr_bus_pkg::*;

    bus_addr_u         adr;
    logic [DATA_W-1:0] dat_w; // Master to slave.
    logic [DATA_W-1:0] dat_r; // Slave to master.
    logic              we;
    logic [SEL_W-1:0]  sel;
    logic              stb;
    logic              ack;

    modport master (
        output adr, dat_w, we, sel, stb,
        input  dat_r, ack
    );

    modport slave (
        input  adr, dat_w, we, sel, stb,
        output dat_r, ack
    );

endinterface

`default_nettype wire

//--- src/wb_mux.sv
`default_nettype none

module wb_mux (
    wb_if.slave  up,
    wb_if.master ram_bus,
    wb_if.master seg_bus,
    wb_if.master gpio_bus
);
    import tenyr_bus_pkg::*;

    target_e target;

    // First matching window wins.
    always_comb begin
        if ((up.adr.word & RAM_MASK) == RAM_BASE) begin
            target = TGT_RAM;
        end else if ((up.adr.word & SEG7_MASK) == SEG7_BASE) begin
            target = TGT_SEG7;
        end else if ((up.adr.word & GPIO_MASK) == GPIO_BASE) begin
            target = TGT_GPIO;
        end else begin
            target = TGT_NONE;
        end
    end

    assign ram_bus.adr   = up.adr;
    assign ram_bus.dat_w = up.dat_w;
    assign ram_bus.we    = up.we;
    assign ram_bus.sel   = up.sel;
    assign ram_bus.stb   = up.stb && (target == TGT_RAM);

    assign seg_bus.adr   = up.adr;
    assign seg_bus.dat_w = up.dat_w;
    assign seg_bus.we    = up.we;
    assign seg_bus.sel   = up.sel;
    assign seg_bus.stb   = up.stb && (target == TGT_SEG7);

    assign gpio_bus.adr   = up.adr;
    assign gpio_bus.dat_w = up.dat_w;
    assign gpio_bus.we    = up.we;
    assign gpio_bus.sel   = up.sel;
    assign gpio_bus.stb   = up.stb && (target == TGT_GPIO);

    always_comb begin
        case (target)
            TGT_RAM: begin
                up.dat_r = ram_bus.dat_r;
                up.ack   = ram_bus.ack;
            end
            TGT_SEG7: begin
                up.dat_r = seg_bus.dat_r;
                up.ack   = seg_bus.ack;
            end
            TGT_GPIO: begin
                up.dat_r = gpio_bus.dat_r;
                up.ack   = gpio_bus.ack;
            end
            default: begin
                // Unmapped, so no device sees the strobe.
                up.dat_r = DEFAULT_DATA;
                up.ack   = up.stb;
            end
        endcase
    end

endmodule

`default_nettype wire
